// ==== sim/frame_buf_wr_testdata.txt ====
// one frame per line, all values hex
// depth reading rd_ptr words exp_ptr mode (0 normal, 1 stream off, 2 port stalled)
// depth 3, reader idle, wrap-around
3 0 0 028 1 0
3 0 0 020 2 0
3 0 0 005 0 0
3 0 0 040 1 0
// depth 3, writer steps around the reader
3 1 2 021 0 0
3 1 1 00a 2 0
3 1 0 01f 1 0
3 1 0 014 2 0
3 1 1 001 0 0
// depth 2
2 0 0 010 1 0
2 0 0 02d 0 0
2 1 1 00c 0 0
2 1 0 046 1 0
2 1 1 008 0 0
3 1 2 003 1 0
// depth 0 taken as 1, then single slot
0 0 0 019 0 0
1 0 0 007 0 0
1 1 0 01e 0 0
// stream disabled, then a normal frame from slot 0
3 0 0 009 0 1
3 0 0 023 1 0
// more than the fifo holds while the port is full
3 0 0 12c 2 2
3 0 0 028 0 0

// ==== frame_buf_wr.f ====
source/frame_buf_cfg_pkg.sv
source/mcb_wr_pkg.sv
source/front_fifo.sv
source/wr_ptr_ctrl.sv
source/burst_wr_fsm.sv
source/frame_buf_wr.sv
sim/frame_buf_wr_tb.sv

// ==== Makefile ====
# verilator build and run of the frame buffer write side testbench

VERILATOR   ?= verilator
TOP         ?= frame_buf_wr_tb
FILELIST    ?= frame_buf_wr.f
BUILD_DIR   ?= obj_dir
JOBS        ?= 4
EXTRA_FLAGS ?=

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "make test    build with verilator and run the testbench"
	@echo "make clean   remove the build directory"
	@echo "make help    show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR JOBS EXTRA_FLAGS"

test:
	$(VERILATOR) --binary --timing --assert -j $(JOBS) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -f $(FILELIST) $(EXTRA_FLAGS)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

// ==== sim/frame_buf_wr_tb.sv ====
// testbench for the frame buffer write side
// frames come from a data file, a memory controller model checks words and commands
`timescale 1ns/100ps

module frame_buf_wr_tb
	import frame_buf_cfg_pkg::*;
	import mcb_wr_pkg::*;
();

	localparam logic [15:0] LFSR_SEED     = 16'd20217;
	// columns per frame line in the data file
	localparam int          FIELDS        = 6;
	localparam int          MAX_FRAMES    = 32;
	localparam int          GAP_CYCLES    = 10;
	localparam int          FRAME_TIMEOUT = 4000;

	logic                 clk;
	logic                 reset;
	logic                 i_fval;
	logic                 i_dval;
	logic [DATA_WD-1:0]   i_pixel;
	logic                 o_front_fifo_overflow;
	logic                 i_stream_enable;
	logic [PTR_WIDTH-1:0] i_frame_depth;
	rd_status_t           i_rd_status;
	logic [PTR_WIDTH-1:0] o_wr_ptr;
	logic                 o_wr_ptr_change;
	logic                 o_writing;
	logic [PTR_WIDTH-1:0] o_frame_depth;
	logic                 i_calib_done;
	logic                 o_wr_cmd_en;
	mcb_wr_cmd_t          o_wr_cmd;
	logic                 i_wr_cmd_full;
	logic                 o_wr_en;
	logic [DATA_WD-1:0]   o_wr_data;
	logic                 i_wr_full;

	// --------------------------------------------------
	// stimulus state, owned by the main process
	// --------------------------------------------------
	logic [15:0]          td [FIELDS*MAX_FRAMES];
	logic [DATA_WD-1:0]   word_mem [512];
	logic [15:0]          lfsr;
	logic [PTR_WIDTH-1:0] exp_ptr;
	int                   depth_eff;
	int                   mode;
	int                   exp_words;
	int                   frame_no;
	logic                 drop;
	logic                 hold_full;
	logic                 ovf_exp;
	logic                 ptr_pending;
	logic                 ptr_checked;

	// controller model counters, owned by the model process
	int                   model_frame;
	int                   rd_idx;
	int                   words_since;
	int                   cmd_cnt;
	int                   burst_idx;

	frame_buf_wr frame_buf_wr_i (.*);

	always #2 clk = ~clk;

	// --------------------------------------------------
	// error reporting
	// --------------------------------------------------
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("test failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic value_error(input string name, input logic [63:0] exp, input logic [63:0] got);
		abort_run($sformatf("error at %0t: %s expected %h got %h", $time, name, exp, got));
	endtask

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// one lfsr step per bit taken
	task automatic draw_bits(input int n, output logic [63:0] v);
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v    = {v[62:0], lfsr[0]};
		end
	endtask

	// pointer field takes the top k bits of the burst address, k bits to count to depth
	function automatic logic [BYTE_ADDR_WIDTH-1:0] expected_addr(input int depth,
		input logic [PTR_WIDTH-1:0] ptr, input int burst);
		int k;
		int low_span;
		int field;
		k        = (depth > 2) ? 2 : depth - 1;
		low_span = 1 << (WR_ADDR_WIDTH - k);
		field    = (burst % low_span) + (int'(ptr) % (1 << k)) * low_span;
		return BYTE_ADDR_WIDTH'(field * (1 << BURST_BYTE_SHIFT));
	endfunction

	// falling edge, check registered outputs, then drive back-pressure
	task automatic next_cycle();
		logic [63:0] b;
		@(negedge clk);
		// pointer and writing settle one cycle after the change pulse
		if (ptr_pending) begin
			assert (o_wr_ptr == exp_ptr)
				else value_error("o_wr_ptr", 64'(exp_ptr), 64'(o_wr_ptr));
			assert (o_writing == !drop)
				else value_error("o_writing", 64'(!drop), 64'(o_writing));
			ptr_checked = 1'b1;
		end
		ptr_pending = o_wr_ptr_change;
		if (o_wr_ptr_change) begin
			assert (mode != 1) else abort_run("pointer changed while the stream was disabled");
		end
		if (mode == 2) begin
			i_wr_full     = hold_full;
			i_wr_cmd_full = 1'b0;
		end else begin
			draw_bits(1, b);
			i_wr_full = b[0];
			draw_bits(1, b);
			i_wr_cmd_full = b[0];
		end
	endtask

	// --------------------------------------------------
	// one frame from line f of the data file
	// --------------------------------------------------
	task automatic run_frame(input int f);
		logic [DATA_WD-1:0] word;
		int                 n;
		int                 i;
		int                 wait_cnt;
		depth_eff               = (td[FIELDS*f] == 16'h0) ? 1 : int'(td[FIELDS*f]);
		i_frame_depth           = td[FIELDS*f][PTR_WIDTH-1:0];
		i_rd_status.reading     = td[FIELDS*f+1][0];
		i_rd_status.rd_ptr      = td[FIELDS*f+2][PTR_WIDTH-1:0];
		n                       = int'(td[FIELDS*f+3]);
		exp_ptr                 = td[FIELDS*f+4][PTR_WIDTH-1:0];
		mode                    = int'(td[FIELDS*f+5]);
		// single slot with a busy reader drops the frame
		drop                    = (depth_eff == 1) && td[FIELDS*f+1][0];
		hold_full               = (mode == 2);
		i_stream_enable         = (mode != 1);
		exp_words               = (mode == 1 || drop) ? 0 : n;
		// a stalled port keeps only what the fifo holds
		if (mode == 2 && n > FRONT_FIFO_DEPTH) begin
			exp_words = FRONT_FIFO_DEPTH;
		end
		ptr_checked = 1'b0;
		frame_no++;
		next_cycle();
		next_cycle();

		for (i = 0; i < n; i++) begin
			next_cycle();
			draw_bits(DATA_WD, word);
			i_fval  = 1'b1;
			i_dval  = 1'b1;
			i_pixel = word;
			if (i < exp_words) begin
				word_mem[i] = word;
			end
		end
		hold_full = 1'b0;
		next_cycle();
		i_fval = 1'b0;
		i_dval = 1'b0;

		// frame done when writing falls, a dropped frame only needs its pointer check
		if (mode != 1) begin
			wait_cnt = 0;
			while (!ptr_checked || (!drop && o_writing)) begin
				next_cycle();
				wait_cnt++;
				assert (wait_cnt < FRAME_TIMEOUT)
					else abort_run("timeout waiting for the end of a frame");
			end
		end
		// stopping the stream flushes the words of a dropped frame
		if (drop) begin
			i_stream_enable = 1'b0;
		end
		for (i = 0; i < GAP_CYCLES; i++) begin
			next_cycle();
		end

		if (mode == 2) begin
			ovf_exp = 1'b1;
		end
		assert (rd_idx == exp_words)
			else value_error("written word count", 64'(exp_words), 64'(rd_idx));
		assert (cmd_cnt == (exp_words + BURST_SIZE - 1) / BURST_SIZE)
			else value_error("command count", 64'((exp_words + BURST_SIZE - 1) / BURST_SIZE),
				64'(cmd_cnt));
		assert (o_front_fifo_overflow == ovf_exp)
			else value_error("o_front_fifo_overflow", 64'(ovf_exp), 64'(o_front_fifo_overflow));
		assert (o_writing == 1'b0) else value_error("o_writing", 64'(0), 64'(o_writing));
		// depth zero reads back as one
		assert (o_frame_depth == PTR_WIDTH'(depth_eff))
			else value_error("o_frame_depth", 64'(depth_eff), 64'(o_frame_depth));
		if (mode == 1) begin
			assert (o_wr_ptr == exp_ptr)
				else value_error("o_wr_ptr", 64'(exp_ptr), 64'(o_wr_ptr));
		end
	endtask

	// --------------------------------------------------
	// memory controller model, accepts on the rising edge
	// --------------------------------------------------
	always @(posedge clk) begin
		if (frame_no != model_frame) begin
			model_frame = frame_no;
			rd_idx      = 0;
			words_since = 0;
			cmd_cnt     = 0;
			burst_idx   = 0;
		end
		if (!reset && o_wr_en) begin
			assert (rd_idx < exp_words) else abort_run("word written beyond the frame's words");
			assert (o_wr_data == word_mem[rd_idx])
				else value_error("o_wr_data", word_mem[rd_idx], o_wr_data);
			rd_idx++;
			words_since++;
		end
		if (!reset && o_wr_cmd_en) begin
			assert (words_since > 0 && words_since <= BURST_SIZE)
				else abort_run("command issued with no words or more than one burst");
			assert (int'(o_wr_cmd.bl) == words_since - 1)
				else value_error("o_wr_cmd.bl", 64'(words_since - 1), 64'(o_wr_cmd.bl));
			assert (o_wr_cmd.byte_addr == expected_addr(depth_eff, exp_ptr, burst_idx))
				else value_error("o_wr_cmd.byte_addr",
					64'(expected_addr(depth_eff, exp_ptr, burst_idx)), 64'(o_wr_cmd.byte_addr));
			burst_idx++;
			cmd_cnt++;
			words_since = 0;
		end
	end

	initial begin
		int f;
		clk             = 1'b0;
		reset           = 1'b1;
		i_fval          = 1'b0;
		i_dval          = 1'b0;
		i_pixel         = '0;
		i_stream_enable = 1'b1;
		i_frame_depth   = '0;
		i_rd_status     = '0;
		i_calib_done    = 1'b0;
		i_wr_cmd_full   = 1'b0;
		i_wr_full       = 1'b0;
		lfsr            = LFSR_SEED;
		mode            = 0;
		drop            = 1'b0;
		hold_full       = 1'b0;
		ovf_exp         = 1'b0;
		ptr_pending     = 1'b0;
		ptr_checked     = 1'b0;
		exp_ptr         = '0;
		depth_eff       = 1;
		exp_words       = 0;
		frame_no        = 0;
		model_frame     = 0;
		rd_idx          = 0;
		words_since     = 0;
		cmd_cnt         = 0;
		burst_idx       = 0;
		// unused lines stay all ones and end the frame list
		for (f = 0; f < FIELDS * MAX_FRAMES; f++) begin
			td[f] = '1;
		end
		$readmemh("sim/frame_buf_wr_testdata.txt", td);

		for (f = 0; f < 5; f++) begin
			next_cycle();
		end
		assert ({o_wr_en, o_wr_cmd_en, o_wr_ptr_change, o_writing, o_front_fifo_overflow} == 5'b0)
			else abort_run("outputs are not low during reset");
		reset        = 1'b0;
		i_calib_done = 1'b1;
		// calibration passes the two sync flops
		for (f = 0; f < GAP_CYCLES; f++) begin
			next_cycle();
		end

		f = 0;
		while (f < MAX_FRAMES && td[FIELDS*f] != 16'hffff) begin
			run_frame(f);
			f++;
		end
		assert (f > 0) else abort_run("no frames were read from the data file");
		$display("test passed");
		$finish;
	end

endmodule

// ==== source/frame_buf_wr.sv ====
// frame buffer write side top
// front fifo, burst FSM and frame pointer control
`timescale 1ns/100ps

module frame_buf_wr
	import frame_buf_cfg_pkg::*;
	import mcb_wr_pkg::*;
(
	input  logic                 clk,
	input  logic                 reset,
	// camera stream
	input  logic                 i_fval,
	input  logic                 i_dval,
	input  logic [DATA_WD-1:0]   i_pixel,
	output logic                 o_front_fifo_overflow,
	// control and read side
	input  logic                 i_stream_enable,
	input  logic [PTR_WIDTH-1:0] i_frame_depth,
	input  rd_status_t           i_rd_status,
	output logic [PTR_WIDTH-1:0] o_wr_ptr,
	output logic                 o_wr_ptr_change,
	output logic                 o_writing,
	output logic [PTR_WIDTH-1:0] o_frame_depth,
	// memory controller
	input  logic                 i_calib_done,
	output logic                 o_wr_cmd_en,
	output mcb_wr_cmd_t          o_wr_cmd,
	input  logic                 i_wr_cmd_full,
	output logic                 o_wr_en,
	output logic [DATA_WD-1:0]   o_wr_data,
	input  logic                 i_wr_full
);

	logic [DATA_WD-1:0] fifo_head;
	logic               fifo_empty;
	logic               fifo_clear;
	logic               fifo_pop;
	logic               in_ptr;
	logic               in_idle;
	logic               stream_on;
	logic               frame_drop;

	// --------------------------------------------------
	// front fifo, pushes gated by full inside
	// --------------------------------------------------
	front_fifo front_fifo_i (
		.clk         (clk),
		.reset       (reset),
		.i_clear     (fifo_clear),
		.i_push      (i_fval & i_dval),
		.i_push_data (i_pixel),
		.i_pop       (fifo_pop),
		.o_head      (fifo_head),
		.o_empty     (fifo_empty),
		.o_full      (),
		.o_overflow  (o_front_fifo_overflow)
	);

	burst_wr_fsm burst_wr_fsm_i (
		.clk             (clk),
		.reset           (reset),
		.i_fval          (i_fval),
		.i_stream_enable (i_stream_enable),
		.i_calib_done    (i_calib_done),
		.i_fifo_head     (fifo_head),
		.i_fifo_empty    (fifo_empty),
		.i_wr_full       (i_wr_full),
		.i_wr_cmd_full   (i_wr_cmd_full),
		.i_wr_ptr        (o_wr_ptr),
		.i_depth         (o_frame_depth),
		.i_ptr_change    (o_wr_ptr_change),
		.i_frame_drop    (frame_drop),
		.o_fifo_clear    (fifo_clear),
		.o_fifo_pop      (fifo_pop),
		.o_in_ptr        (in_ptr),
		.o_in_idle       (in_idle),
		.o_stream_on     (stream_on),
		.o_wr_en         (o_wr_en),
		.o_wr_data       (o_wr_data),
		.o_wr_cmd_en     (o_wr_cmd_en),
		.o_wr_cmd        (o_wr_cmd)
	);

	// pointer and flags toward the reader
	wr_ptr_ctrl wr_ptr_ctrl_i (
		.clk           (clk),
		.reset         (reset),
		.i_in_ptr      (in_ptr),
		.i_in_idle     (in_idle),
		.i_stream_on   (stream_on),
		.i_frame_depth (i_frame_depth),
		.i_rd_status   (i_rd_status),
		.o_wr_ptr      (o_wr_ptr),
		.o_depth       (o_frame_depth),
		.o_ptr_change  (o_wr_ptr_change),
		.o_frame_drop  (frame_drop),
		.o_writing     (o_writing)
	);

endmodule

// ==== source/burst_wr_fsm.sv ====
// frame and burst FSM, drains the front fifo into the controller write port
// issues one command per burst and packs the byte address from pointer and depth
`timescale 1ns/100ps

module burst_wr_fsm
	import frame_buf_cfg_pkg::*;
	import mcb_wr_pkg::*;
(
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 i_fval,
	input  logic                 i_stream_enable,
	input  logic                 i_calib_done,
	input  logic [DATA_WD-1:0]   i_fifo_head,
	input  logic                 i_fifo_empty,
	input  logic                 i_wr_full,
	input  logic                 i_wr_cmd_full,
	input  logic [PTR_WIDTH-1:0] i_wr_ptr,
	input  logic [PTR_WIDTH-1:0] i_depth,
	input  logic                 i_ptr_change,
	input  logic                 i_frame_drop,
	output logic                 o_fifo_clear,
	output logic                 o_fifo_pop,
	output logic                 o_in_ptr,
	output logic                 o_in_idle,
	output logic                 o_stream_on,
	output logic                 o_wr_en,
	output logic [DATA_WD-1:0]   o_wr_data,
	output logic                 o_wr_cmd_en,
	output mcb_wr_cmd_t          o_wr_cmd
);

	wr_state_t                 state;
	wr_state_t                 next_state;
	logic                      fval_dly;
	logic                      fval_rise;
	logic                      stream_en_reg;
	logic                      stream_on;
	logic [1:0]                calib_sync;
	logic [WORD_CNT_WIDTH-1:0] word_cnt;
	logic [WR_ADDR_WIDTH-1:0]  wr_addr;
	logic [WR_ADDR_WIDTH-1:0]  packed_addr;
	logic                      cmd_en;
	logic                      pop;
	logic                      none_pending;
	logic                      drained;

	// --------------------------------------------------
	// input conditioning
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			fval_dly      <= 1'b0;
			stream_en_reg <= 1'b0;
			calib_sync    <= 2'b00;
		end else begin
			fval_dly   <= i_fval;
			calib_sync <= {calib_sync[0], i_calib_done};
			// enable only takes hold at a frame start
			if (!i_stream_enable) begin
				stream_en_reg <= 1'b0;
			end else if (fval_rise) begin
				stream_en_reg <= 1'b1;
			end
		end
	end

	assign fval_rise    = i_fval & ~fval_dly;
	// disable acts at once
	assign stream_on    = stream_en_reg & i_stream_enable;
	// flush leftovers at each frame start and while stopped
	assign o_fifo_clear = fval_rise | ~stream_on;

	// all ones or a command going out means no word pending
	assign none_pending = (word_cnt == WORD_CNT_WIDTH'(BURST_SIZE - 1)) || cmd_en;
	assign drained      = i_fifo_empty & ~i_fval;
	// no word moves in the cycle the command goes out
	assign pop = (state == S_WR) && !i_fifo_empty && !i_wr_full && stream_on && !cmd_en;

	// --------------------------------------------------
	// state machine
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= S_IDLE;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			S_IDLE: begin
				if (stream_on && calib_sync[1] && !i_fifo_empty) begin
					next_state = S_PTR;
				end
			end
			// two cycles, leave on the pointer change
			S_PTR: begin
				if (i_ptr_change) begin
					next_state = i_frame_drop ? S_IDLE : S_WR;
				end
			end
			S_WR: begin
				if ((drained || !stream_on) && none_pending) begin
					next_state = S_IDLE;
				end else if ((pop && word_cnt == WORD_CNT_WIDTH'(BURST_SIZE - 2)) ||
					drained || !stream_on) begin
					// full burst, or partial one at frame end or stop
					next_state = S_CMD;
				end
			end
			S_CMD: begin
				if (!i_wr_cmd_full) begin
					next_state = S_WR;
				end
			end
			default: next_state = S_IDLE;
		endcase
	end

	// --------------------------------------------------
	// word counter, burst address, command strobe
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset || state == S_IDLE) begin
			word_cnt <= '1;
			wr_addr  <= '0;
		end else begin
			if (cmd_en) begin
				// next burst counts from all ones again
				word_cnt <= '1;
				wr_addr  <= wr_addr + 1'b1;
			end else if (pop) begin
				word_cnt <= word_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			cmd_en <= 1'b0;
		end else begin
			cmd_en <= (state == S_CMD) && !i_wr_cmd_full;
		end
	end

	// top bits of the burst address carry the pointer, as many as the depth needs
	always_comb begin
		packed_addr = wr_addr;
		if (i_depth == PTR_WIDTH'(2)) begin
			packed_addr[WR_ADDR_WIDTH-1] = i_wr_ptr[0];
		end else if (i_depth > PTR_WIDTH'(2)) begin
			packed_addr[WR_ADDR_WIDTH-1 -: PTR_WIDTH] = i_wr_ptr;
		end
	end

	// word_cnt and wr_addr are still steady while cmd_en is high
	assign o_wr_cmd.bl        = {{(MCB_BL_WIDTH-WORD_CNT_WIDTH){1'b0}}, word_cnt};
	assign o_wr_cmd.byte_addr = {{(BYTE_ADDR_WIDTH-WR_ADDR_WIDTH-BURST_BYTE_SHIFT){1'b0}},
		packed_addr, {BURST_BYTE_SHIFT{1'b0}}};

	assign o_wr_cmd_en = cmd_en;
	assign o_fifo_pop  = pop;
	assign o_wr_en     = pop;
	assign o_wr_data   = i_fifo_head;
	assign o_in_ptr    = (state == S_PTR);
	assign o_in_idle   = (state == S_IDLE);
	assign o_stream_on = stream_on;

	a_data_cmd_apart: assert property (@(posedge clk) disable iff (reset)
		!(o_wr_en && o_wr_cmd_en));

endmodule

// ==== source/wr_ptr_ctrl.sv ====
// frame slot write pointer, steps around the slot the reader holds
// also keeps the frame depth and the flags toward the read side
`timescale 1ns/100ps

module wr_ptr_ctrl
	import frame_buf_cfg_pkg::*;
	import mcb_wr_pkg::*;
(
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 i_in_ptr,
	input  logic                 i_in_idle,
	input  logic                 i_stream_on,
	input  logic [PTR_WIDTH-1:0] i_frame_depth,
	input  rd_status_t           i_rd_status,
	output logic [PTR_WIDTH-1:0] o_wr_ptr,
	output logic [PTR_WIDTH-1:0] o_depth,
	output logic                 o_ptr_change,
	output logic                 o_frame_drop,
	output logic                 o_writing
);

	logic [PTR_WIDTH-1:0] depth_reg;
	logic [PTR_WIDTH-1:0] wr_ptr;
	logic [PTR_WIDTH-1:0] depth_max;
	logic [PTR_WIDTH-1:0] ptr_inc;
	logic [PTR_WIDTH-1:0] rd_inc;
	logic                 ptr_change;

	// --------------------------------------------------
	// depth, sampled only between frames
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			depth_reg <= PTR_WIDTH'(1);
		end else if (i_in_idle) begin
			// zero depth is taken as one frame
			depth_reg <= (i_frame_depth == '0) ? PTR_WIDTH'(1) : i_frame_depth;
		end
	end

	// high for the second ptr cycle only
	always_ff @(posedge clk) begin
		if (reset) begin
			ptr_change <= 1'b0;
		end else begin
			ptr_change <= i_in_ptr & ~ptr_change;
		end
	end

	assign depth_max    = depth_reg - 1'b1;
	assign ptr_inc      = wr_ptr + 1'b1;
	assign rd_inc       = i_rd_status.rd_ptr + 1'b1;
	// single slot and reader busy, nowhere to write
	assign o_frame_drop = (depth_reg == PTR_WIDTH'(1)) && i_rd_status.reading;

	// --------------------------------------------------
	// pointer rotation
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset || !i_stream_on || depth_reg == PTR_WIDTH'(1)) begin
			wr_ptr <= '0;
		end else if (ptr_change) begin
			// >= covers a depth lowered below the current pointer
			if (i_rd_status.reading) begin
				if (wr_ptr >= depth_max) begin
					wr_ptr <= (i_rd_status.rd_ptr == '0) ? PTR_WIDTH'(1) : '0;
				end else if (ptr_inc == i_rd_status.rd_ptr) begin
					// jump over the reader slot
					wr_ptr <= (i_rd_status.rd_ptr == depth_max) ? '0 : rd_inc;
				end else begin
					wr_ptr <= ptr_inc;
				end
			end else begin
				wr_ptr <= (wr_ptr >= depth_max) ? '0 : ptr_inc;
			end
		end
	end

	// writing changes together with the pointer
	always_ff @(posedge clk) begin
		if (reset || i_in_idle) begin
			o_writing <= 1'b0;
		end else if (ptr_change) begin
			o_writing <= ~o_frame_drop;
		end
	end

	assign o_wr_ptr     = wr_ptr;
	assign o_depth      = depth_reg;
	assign o_ptr_change = ptr_change;

	a_ptr_in_range: assert property (@(posedge clk) disable iff (reset)
		ptr_change |=> wr_ptr < depth_reg);

	// new slot never collides with the one being read
	a_skip_reader: assert property (@(posedge clk) disable iff (reset)
		ptr_change && i_stream_on && i_rd_status.reading && depth_reg > PTR_WIDTH'(1)
		|=> wr_ptr != $past(i_rd_status.rd_ptr));

endmodule

// ==== source/front_fifo.sv ====
// front pixel fifo, single clock, first word fall through
// clear input empties it, sticky overflow on push while full
`timescale 1ns/100ps

module front_fifo
	import frame_buf_cfg_pkg::*;
(
	input  logic               clk,
	input  logic               reset,
	input  logic               i_clear,
	input  logic               i_push,
	input  logic [DATA_WD-1:0] i_push_data,
	input  logic               i_pop,
	output logic [DATA_WD-1:0] o_head,
	output logic               o_empty,
	output logic               o_full,
	output logic               o_overflow
);

	logic [DATA_WD-1:0]       mem [FRONT_FIFO_DEPTH];
	// extra msb tells full from empty
	logic [FIFO_ADDR_WIDTH:0] wr_ptr;
	logic [FIFO_ADDR_WIDTH:0] rd_ptr;
	logic                     push_ok;
	logic [FIFO_ADDR_WIDTH-1:0] wr_idx;

	// a clear frees the whole array, so a push in that cycle always lands
	assign push_ok = i_push & (i_clear | ~o_full);
	assign wr_idx  = i_clear ? '0 : wr_ptr[FIFO_ADDR_WIDTH-1:0];

	always_ff @(posedge clk) begin
		if (push_ok) begin
			mem[wr_idx] <= i_push_data;
		end
	end

	// --------------------------------------------------
	// pointers
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else if (i_clear) begin
			// word pushed with the clear becomes the head
			wr_ptr <= {{FIFO_ADDR_WIDTH{1'b0}}, push_ok};
			rd_ptr <= '0;
		end else begin
			if (push_ok) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (i_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	// head is read straight from the array
	assign o_head  = mem[rd_ptr[FIFO_ADDR_WIDTH-1:0]];
	assign o_empty = (wr_ptr == rd_ptr);
	assign o_full  = (wr_ptr[FIFO_ADDR_WIDTH] != rd_ptr[FIFO_ADDR_WIDTH]) &&
		(wr_ptr[FIFO_ADDR_WIDTH-1:0] == rd_ptr[FIFO_ADDR_WIDTH-1:0]);

	// sticky until reset, clear leaves it alone
	always_ff @(posedge clk) begin
		if (reset) begin
			o_overflow <= 1'b0;
		end else if (i_push && o_full && !i_clear) begin
			o_overflow <= 1'b1;
		end
	end

	// the burst FSM only pops a non-empty fifo
	a_no_pop_empty: assert property (@(posedge clk) disable iff (reset)
		i_pop |-> !o_empty);

endmodule

// ==== source/mcb_wr_pkg.sv ====
// memory controller write port types
// command word toward the controller and read side status from the reader
package mcb_wr_pkg;
	import frame_buf_cfg_pkg::*;

	// --------------------------------------------------
	// command port
	// --------------------------------------------------
	// burst length field of the controller, words minus one
	localparam int MCB_BL_WIDTH = 6;

	// one write command, bl in the top bits
	typedef struct packed {
		logic [MCB_BL_WIDTH-1:0]    bl;
		logic [BYTE_ADDR_WIDTH-1:0] byte_addr;
	} mcb_wr_cmd_t;

	// --------------------------------------------------
	// read side status
	// --------------------------------------------------
	// reader busy flag and the slot it holds
	typedef struct packed {
		logic                 reading;
		logic [PTR_WIDTH-1:0] rd_ptr;
	} rd_status_t;

endpackage

// ==== source/frame_buf_cfg_pkg.sv ====
// frame buffer write side configuration
// data, pointer, address and burst sizes plus the burst FSM states
package frame_buf_cfg_pkg;

	// --------------------------------------------------
	// data path
	// --------------------------------------------------
	// pixel word and memory word share one width
	localparam int DATA_WD          = 64;
	// 2 bit frame pointer, up to 4 slots
	localparam int PTR_WIDTH        = 2;

	// --------------------------------------------------
	// memory addressing
	// --------------------------------------------------
	// burst address inside the buffer
	localparam int WR_ADDR_WIDTH    = 10;
	// words per burst and counter width
	localparam int BURST_SIZE       = 32;
	localparam int WORD_CNT_WIDTH   = 5;
	// 32 words of 8 bytes give 8 zero low bits
	localparam int BURST_BYTE_SHIFT = 8;
	localparam int BYTE_ADDR_WIDTH  = 30;

	// front fifo size
	localparam int FRONT_FIFO_DEPTH = 256;
	localparam int FIFO_ADDR_WIDTH  = 8;

	// burst FSM states
	typedef enum logic [1:0] {
		S_IDLE = 2'd0,
		S_PTR  = 2'd1,
		S_WR   = 2'd2,
		S_CMD  = 2'd3
	} wr_state_t;

endpackage
